// File: design/mem_pkg.sv
package mem_pkg;

  // Defaults only; the top level sets its own parameters from these.
  localparam int DATA_WIDTH     = 32;
  localparam int ADDR_WIDTH     = 10;
  localparam int REG_ADDR_WIDTH = 5;

  typedef logic [DATA_WIDTH-1:0]     data_t;
  typedef logic [ADDR_WIDTH-1:0]     addr_t;
  typedef logic [REG_ADDR_WIDTH-1:0] reg_idx_t;

  typedef enum logic [1:0] {
    SIZE_BYTE = 2'b00,
    SIZE_HALF = 2'b01,
    SIZE_WORD = 2'b10
  } access_size_t;

  // One executed instruction from the execute stage.
  typedef struct packed {
    logic         valid;
    logic         is_load;
    logic         is_store;
    logic         reg_wr_en;
    reg_idx_t     wr_reg;
    data_t        alu_result;  // Result or byte address.
    data_t        rs2_data;    // Store data.
    access_size_t size;
  } ex_mem_t;

  // Data memory request with single-cycle rd and wr strobes.
  typedef struct packed {
    logic         rd;
    logic         wr;
    addr_t        addr;
    data_t        wdata;
    access_size_t size;
  } mem_req_t;

  // Writeback commit.
  typedef struct packed {
    logic     wr_en;
    reg_idx_t rd;
    data_t    data;
  } wb_req_t;

endpackage : mem_pkg

// File: design/ex_mem_reg.sv
module ex_mem_reg (
  input  logic             clk_i,
  input  logic             rst_i,
  input  logic             stall_i,
  input  mem_pkg::ex_mem_t instr_i,
  output mem_pkg::ex_mem_t held_o
);

  mem_pkg::ex_mem_t held_q;

  always_ff @(posedge clk_i) begin : hold_flops
    if (!rst_i) begin
      held_q.valid <= 1'b0;  // Valid clears on reset.
    end else if (!stall_i) begin
      held_q <= instr_i;  // Load next instruction.
    end
  end

  assign held_o = held_q;

  // An instruction under stall must not change or vanish before the stage finishes it.
  property p_hold_under_stall;
    @(posedge clk_i) disable iff (!rst_i)
      $past(rst_i) && $past(stall_i) |-> $stable(held_o);
  endproperty

  a_hold_under_stall : assert property (p_hold_under_stall)
    else $error("ex_mem_reg: held instruction changed during stall");

endmodule : ex_mem_reg

// File: design/mem_stage.sv
module mem_stage #(
  parameter int DATA_WIDTH = mem_pkg::DATA_WIDTH,
  parameter int ADDR_WIDTH = mem_pkg::ADDR_WIDTH
) (
  input  logic              clk_i,
  input  logic              rst_i,
  input  mem_pkg::ex_mem_t  instr_i,
  input  logic              rdata_valid_i,
  input  mem_pkg::data_t    rdata_i,
  output mem_pkg::mem_req_t req_o,
  output logic              stall_o,
  output logic              wb_valid_o,
  output mem_pkg::wb_req_t  wb_o
);

  typedef enum logic [1:0] {
    IDLE    = 2'b00,
    READY   = 2'b01,
    WAITING = 2'b10
  } state_t;

  state_t state_q, state_d;

  logic [DATA_WIDTH-1:0] wb_data;
  logic [ADDR_WIDTH-1:0] req_addr;
  logic                  wb_wr_en;

  always_ff @(posedge clk_i) begin : state_flops
    if (!rst_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  assign req_addr = instr_i.alu_result[ADDR_WIDTH-1:0];
  // Load data once the memory answers, otherwise the ALU result.
  assign wb_data  = (state_q == WAITING) ? rdata_i : instr_i.alu_result[DATA_WIDTH-1:0];

  always_comb begin : fsm
    req_o.rd   = 1'b0;
    req_o.wr   = 1'b0;
    req_o.addr = req_addr;
    req_o.wdata = instr_i.rs2_data;
    req_o.size = instr_i.size;
    wb_valid_o = 1'b0;
    wb_wr_en   = 1'b0;
    stall_o    = 1'b0;
    state_d    = state_q;

    case (state_q)
      IDLE: begin
        stall_o = 1'b1;  // Hold upstream for the first cycle.
        state_d = READY;
      end
      READY: begin
        if (instr_i.valid) begin
          req_o.rd   = instr_i.is_load;
          req_o.wr   = instr_i.is_store;
          wb_valid_o = !instr_i.is_load;
          wb_wr_en   = instr_i.is_load ? 1'b0 : instr_i.reg_wr_en;
          stall_o    = instr_i.is_load;
          state_d    = instr_i.is_load ? WAITING : READY;
        end
      end
      WAITING: begin
        stall_o = 1'b1;
        if (rdata_valid_i) begin
          wb_valid_o = 1'b1;
          wb_wr_en   = 1'b1;
          stall_o    = 1'b0;
          state_d    = READY;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  assign wb_o.wr_en = wb_wr_en;
  assign wb_o.rd    = instr_i.wr_reg;
  assign wb_o.data  = wb_data;

  a_rd_wr_exclusive : assert property (@(posedge clk_i) disable iff (!rst_i)
    !(req_o.rd && req_o.wr))
    else $error("mem_stage: rd and wr strobes set together");

  // Memory answers only to a load this stage is waiting for.
  a_rdata_in_waiting : assert property (@(posedge clk_i) disable iff (!rst_i)
    rdata_valid_i |-> state_q == WAITING)
    else $error("mem_stage: read data outside WAITING");

endmodule : mem_stage

// File: design/data_mem.sv
module data_mem #(
  parameter int DEPTH_BYTES  = 1024,
  parameter int READ_LATENCY = 2
) (
  input  logic              clk_i,
  input  logic              rst_i,
  input  mem_pkg::mem_req_t req_i,
  output logic              rdata_valid_o,
  output mem_pkg::data_t    rdata_o
);

  localparam int W      = $bits(mem_pkg::data_t);
  localparam int NBYTES = W / 8;

  // Address and size of a read travelling down the latency line.
  typedef struct packed {
    mem_pkg::addr_t        addr;
    mem_pkg::access_size_t size;
  } rd_tag_t;

  logic [7:0]                mem_q [DEPTH_BYTES];
  logic [READ_LATENCY-1:0]   pipe_valid_q;
  rd_tag_t                   pipe_tag_q [READ_LATENCY];
  rd_tag_t                   out_tag;
  logic [W-1:0]              raw_word;
  int unsigned               wr_bytes;

  always_comb begin : wr_len
    case (req_i.size)
      mem_pkg::SIZE_BYTE: wr_bytes = 1;
      mem_pkg::SIZE_HALF: wr_bytes = 2;
      default:            wr_bytes = NBYTES;
    endcase
  end

  // Little-endian lane writes.
  always_ff @(posedge clk_i) begin : write_port
    if (req_i.wr) begin
      for (int i = 0; i < NBYTES; i++) begin
        if (i < wr_bytes) begin
          mem_q[mem_pkg::addr_t'(req_i.addr + i)] <= req_i.wdata[8*i +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin : latency_valid
    if (!rst_i) begin
      pipe_valid_q <= '0;
    end else begin
      for (int i = READ_LATENCY - 1; i > 0; i--) begin
        pipe_valid_q[i] <= pipe_valid_q[i-1];
      end
      pipe_valid_q[0] <= req_i.rd;
    end
  end

  always_ff @(posedge clk_i) begin : latency_tag
    for (int i = READ_LATENCY - 1; i > 0; i--) begin
      pipe_tag_q[i] <= pipe_tag_q[i-1];
    end
    pipe_tag_q[0] <= '{addr: req_i.addr, size: req_i.size};
  end

  assign out_tag       = pipe_tag_q[READ_LATENCY-1];
  assign rdata_valid_o = pipe_valid_q[READ_LATENCY-1];

  always_comb begin : assemble
    for (int i = 0; i < NBYTES; i++) begin
      raw_word[8*i +: 8] = mem_q[mem_pkg::addr_t'(out_tag.addr + i)];
    end
    case (out_tag.size)
      mem_pkg::SIZE_BYTE: rdata_o = {{(W-8){raw_word[7]}}, raw_word[7:0]};  // Sign extend.
      mem_pkg::SIZE_HALF: rdata_o = {{(W-16){raw_word[15]}}, raw_word[15:0]};
      default:            rdata_o = raw_word;
    endcase
  end

  // One outstanding read at a time.
  a_single_read : assert property (@(posedge clk_i) disable iff (!rst_i)
    req_i.rd |-> pipe_valid_q == '0)
    else $error("data_mem: read issued while another is in flight");

endmodule : data_mem

// File: design/wb_regfile.sv
module wb_regfile (
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic                wb_valid_i,
  input  mem_pkg::wb_req_t    wb_i,
  input  mem_pkg::reg_idx_t   raddr_i,
  output mem_pkg::data_t      rdata_o,
  output logic                commit_valid_o,
  output mem_pkg::wb_req_t    commit_o
);

  localparam int NUM_REGS = 2 ** mem_pkg::REG_ADDR_WIDTH;

  mem_pkg::data_t   regs_q [NUM_REGS];
  logic             commit_valid_q;
  mem_pkg::wb_req_t commit_q;

  always_ff @(posedge clk_i) begin : reg_write
    if (!rst_i) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wb_valid_i && wb_i.wr_en && (wb_i.rd != '0)) begin
      regs_q[wb_i.rd] <= wb_i.data;  // x0 is never written.
    end
  end

  assign rdata_o = (raddr_i == '0) ? '0 : regs_q[raddr_i];

  always_ff @(posedge clk_i) begin : commit_valid_flop
    if (!rst_i) begin
      commit_valid_q <= 1'b0;
    end else begin
      commit_valid_q <= wb_valid_i;
    end
  end

  // Report every commit, writes or not.
  always_ff @(posedge clk_i) begin : commit_flop
    if (wb_valid_i) begin
      commit_q <= wb_i;
    end
  end

  assign commit_valid_o = commit_valid_q;
  assign commit_o       = commit_q;

endmodule : wb_regfile

// File: design/mem_subsystem.sv
module mem_subsystem #(
  parameter int DATA_WIDTH   = mem_pkg::DATA_WIDTH,
  parameter int ADDR_WIDTH   = mem_pkg::ADDR_WIDTH,
  parameter int DEPTH_BYTES  = 1024,
  parameter int READ_LATENCY = 2
) (
  input  logic              clk_i,
  input  logic              rst_i,
  input  mem_pkg::ex_mem_t  instr_i,
  output logic              stall_o,
  output logic              commit_valid_o,
  output mem_pkg::wb_req_t  commit_o,
  input  mem_pkg::reg_idx_t rf_raddr_i,
  output mem_pkg::data_t    rf_rdata_o
);

  mem_pkg::ex_mem_t  held;
  mem_pkg::mem_req_t mem_req;
  mem_pkg::data_t    rdata;
  mem_pkg::wb_req_t  wb;
  logic              rdata_valid;
  logic              stall;
  logic              wb_valid;

  ex_mem_reg u_ex_mem_reg (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .stall_i (stall),
    .instr_i (instr_i),
    .held_o  (held)
  );

  mem_stage #(
    .DATA_WIDTH (DATA_WIDTH),
    .ADDR_WIDTH (ADDR_WIDTH)
  ) u_mem_stage (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .instr_i       (held),
    .rdata_valid_i (rdata_valid),
    .rdata_i       (rdata),
    .req_o         (mem_req),
    .stall_o       (stall),
    .wb_valid_o    (wb_valid),
    .wb_o          (wb)
  );

  data_mem #(
    .DEPTH_BYTES  (DEPTH_BYTES),
    .READ_LATENCY (READ_LATENCY)
  ) u_data_mem (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .req_i         (mem_req),
    .rdata_valid_o (rdata_valid),
    .rdata_o       (rdata)
  );

  wb_regfile u_wb_regfile (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .wb_valid_i     (wb_valid),
    .wb_i           (wb),
    .raddr_i        (rf_raddr_i),
    .rdata_o        (rf_rdata_o),
    .commit_valid_o (commit_valid_o),
    .commit_o       (commit_o)
  );

  assign stall_o = stall;

endmodule : mem_subsystem

// File: dv/tb_mem_subsystem.sv
module tb_mem_subsystem;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int RL         = 2;
  localparam int FIELDS     = 7;  // Words per case line.
  localparam int MAX_CASES  = 64;
  localparam int KIND_LOAD  = 1;
  localparam int KIND_STORE = 2;

  logic                clk_i = 1'b0;
  logic                rst_i;
  mem_pkg::ex_mem_t    instr_i;
  logic                stall_o;
  logic                commit_valid_o;
  mem_pkg::wb_req_t    commit_o;
  mem_pkg::reg_idx_t   rf_raddr_i;
  mem_pkg::data_t      rf_rdata_o;

  logic [31:0]         case_words [MAX_CASES*FIELDS];
  mem_pkg::data_t      model_regs [32];
  mem_pkg::wb_req_t    exp_q [$];
  int                  due_q [$];
  int                  idx_q [$];
  logic [31:0]         lfsr_state = 32'h5882946b;
  int                  cyc = 0;
  int                  limit = 0;
  int                  num_cases = 0;
  int                  errors = 0;
  int                  commits = 0;
  int                  load_start = -1;

  mem_subsystem #(
    .DATA_WIDTH   (mem_pkg::DATA_WIDTH),
    .ADDR_WIDTH   (mem_pkg::ADDR_WIDTH),
    .DEPTH_BYTES  (1024),
    .READ_LATENCY (RL)
  ) u_mem_subsystem (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .instr_i        (instr_i),
    .stall_o        (stall_o),
    .commit_valid_o (commit_valid_o),
    .commit_o       (commit_o),
    .rf_raddr_i     (rf_raddr_i),
    .rf_rdata_o     (rf_rdata_o)
  );

  always #10 clk_i = ~clk_i;

  always @(posedge clk_i) begin : watchdog
    cyc <= cyc + 1;
    if (limit > 0 && cyc >= limit) begin
      $display("Timeout: run stopped after %0d cycles with commits outstanding", cyc);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  // Galois LFSR stepped once per bit.
  function automatic logic rand_bit();
    logic b;
    b = lfsr_state[0];
    lfsr_state = (lfsr_state >> 1) ^ (b ? 32'h80200003 : 32'h0);
    return b;
  endfunction

  function automatic int draw_gap();
    logic hi;
    logic lo;
    hi = rand_bit();
    lo = rand_bit();
    return int'({hi, lo});
  endfunction

  task automatic check_commit(input mem_pkg::wb_req_t got, input mem_pkg::wb_req_t exp);
    if (got !== exp) begin
      $display("ERROR @%0t: commit wr_en %0b rd %0d data %08h, expected wr_en %0b rd %0d data %08h",
               $time, got.wr_en, got.rd, got.data, exp.wr_en, exp.rd, exp.data);
      errors++;
    end
  endtask

  task automatic check_reg(input mem_pkg::reg_idx_t idx, input mem_pkg::data_t exp);
    if (rf_rdata_o !== exp) begin
      $display("ERROR @%0t: x%0d reads %08h, expected %08h", $time, idx, rf_rdata_o, exp);
      errors++;
    end
  endtask

  task automatic check_level(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERROR @%0t: %s is %b, expected %b", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic drive_case(input int idx);
    int base;
    base = idx * FIELDS;
    instr_i.valid      = 1'b1;
    instr_i.is_load    = (case_words[base] == KIND_LOAD);
    instr_i.is_store   = (case_words[base] == KIND_STORE);
    instr_i.size       = mem_pkg::access_size_t'(case_words[base+1][1:0]);
    instr_i.alu_result = case_words[base+2];
    instr_i.rs2_data   = case_words[base+3];
    instr_i.wr_reg     = mem_pkg::reg_idx_t'(case_words[base+4]);
    instr_i.reg_wr_en  = case_words[base+5][0];
  endtask

  // Called right after the accepting edge.
  task automatic accept_case(input int idx);
    mem_pkg::wb_req_t exp;
    int               base;
    logic             is_load;
    base       = idx * FIELDS;
    is_load    = (case_words[base] == KIND_LOAD);
    exp.wr_en  = is_load ? 1'b1 : case_words[base+5][0];  // Loads always write back.
    exp.rd     = mem_pkg::reg_idx_t'(case_words[base+4]);
    exp.data   = case_words[base+6];
    exp_q.push_back(exp);
    due_q.push_back(cyc + (is_load ? RL + 1 : 1));
    idx_q.push_back(idx);
    if (exp.wr_en && exp.rd != '0) model_regs[exp.rd] = exp.data;
    if (is_load) load_start = cyc;
  endtask

  task automatic take_commit();
    mem_pkg::wb_req_t exp;
    int               due;
    int               idx;
    int               errs_before;
    commits++;
    if (exp_q.size() == 0) begin
      $display("Commit seen at %0t with no instruction outstanding", $time);
      errors++;
    end else begin
      exp         = exp_q.pop_front();
      due         = due_q.pop_front();
      idx         = idx_q.pop_front();
      errs_before = errors;
      check_commit(commit_o, exp);
      if (cyc != due) begin
        $display("ERROR @%0t: case %0d committed in cycle %0d, expected cycle %0d",
                 $time, idx, cyc, due);
        errors++;
      end
      $display("case %0d: x%0d data %08h wr_en %0b %s", idx, exp.rd, exp.data, exp.wr_en,
               (errors == errs_before) ? "ok" : "FAILED");
    end
  endtask

  initial begin : main
    int   cur;
    int   gap_left;
    logic offering;
    logic stall_low;
    logic first_cycle;
    logic done;
    rst_i      = 1'b0;
    instr_i    = '0;
    rf_raddr_i = '0;
    cur        = 0;
    gap_left   = 0;
    offering   = 1'b0;
    for (int r = 0; r < 32; r++) model_regs[r] = '0;
    $readmemh("dv/mem_cases.txt", case_words);
    while (num_cases < MAX_CASES && !$isunknown(case_words[num_cases*FIELDS])) num_cases++;
    if (num_cases == 0) begin
      $display("Case file dv/mem_cases.txt held no cases");
      errors++;
    end
    limit = num_cases * (RL + 6) + 50;

    repeat (3) @(posedge clk_i);
    #1;
    rst_i = 1'b1;
    if (num_cases > 0) begin
      drive_case(0);  // Offered in the IDLE cycle.
      offering = 1'b1;
    end
    first_cycle = 1'b1;
    done        = (num_cases == 0);

    while (!done) begin
      @(negedge clk_i);
      stall_low = !stall_o;
      if (first_cycle) begin
        check_level("stall_o after reset", stall_o, 1'b1);
        check_level("commit_valid_o after reset", commit_valid_o, 1'b0);
        first_cycle = 1'b0;
      end
      if (load_start >= 0) begin
        if (cyc < load_start + RL) begin
          check_level("stall_o during load", stall_o, 1'b1);
        end else begin
          check_level("stall_o with load data", stall_o, 1'b0);
          load_start = -1;
        end
      end
      if (commit_valid_o) take_commit();

      @(posedge clk_i);
      #1;
      if (offering && stall_low) begin
        accept_case(cur);
        cur++;
        offering      = 1'b0;
        gap_left      = draw_gap();
        instr_i.valid = 1'b0;
      end
      if (!offering && cur < num_cases) begin
        if (gap_left == 0) begin
          drive_case(cur);
          offering = 1'b1;
        end else begin
          gap_left--;
        end
      end
      done = (cur >= num_cases) && (exp_q.size() == 0);
    end

    // Register file sweep with no commit expected.
    for (int r = 0; r < 32; r++) begin
      @(posedge clk_i);
      #1;
      rf_raddr_i = mem_pkg::reg_idx_t'(r);
      @(negedge clk_i);
      if (commit_valid_o) begin
        $display("Extra commit at %0t after all cases finished", $time);
        errors++;
      end
      check_reg(mem_pkg::reg_idx_t'(r), model_regs[r]);
    end
    if (commits != num_cases) begin
      $display("Commit count %0d does not match case count %0d", commits, num_cases);
      errors++;
    end

    $display("Summary: %0d cases, %0d commits, %0d errors", num_cases, commits, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule : tb_mem_subsystem

// File: dv/mem_cases.txt
// kind (0 alu, 1 load, 2 store)  size (0 byte, 1 half, 2 word)  alu_or_addr  store_data
// rd  wr_en  expected_commit_data
0 2 00000011 00000000 01 1 00000011
0 2 DEADBEEF 00000000 02 1 DEADBEEF
2 2 00000100 12345678 00 0 00000100
1 2 00000100 00000000 03 1 12345678
2 0 00000101 AAAAAA80 00 0 00000101
1 0 00000101 00000000 04 1 FFFFFF80
1 2 00000100 00000000 05 1 12348078
2 1 00000104 5555F00D 00 0 00000104
1 1 00000104 00000000 06 1 FFFFF00D
2 1 00000106 00007FFE 00 0 00000106
1 1 00000106 00000000 07 1 00007FFE
1 2 00000104 00000000 08 1 7FFEF00D
1 0 00000102 00000000 09 1 00000034
0 2 CAFEF00D 00000000 00 1 CAFEF00D
0 2 0BADF00D 00000000 01 0 0BADF00D
1 2 00000100 00000000 00 1 12348078
2 0 00000200 0000007F 00 0 00000200
1 0 00000200 00000000 0A 1 0000007F
0 2 00000042 00000000 0B 1 00000042
1 0 00000100 00000000 0C 1 00000078
0 2 00000777 00000000 02 1 00000777

// File: all.f
design/mem_pkg.sv
design/ex_mem_reg.sv
design/mem_stage.sv
design/data_mem.sv
design/wb_regfile.sv
design/mem_subsystem.sv
dv/tb_mem_subsystem.sv

// File: Bender.yml
package:
  name: mem_subsystem

sources:
  - files:
      - design/mem_pkg.sv
      - design/ex_mem_reg.sv
      - design/mem_stage.sv
      - design/data_mem.sv
      - design/wb_regfile.sv
      - design/mem_subsystem.sv
  - target: test
    files:
      - dv/tb_mem_subsystem.sv
